//--- vlog.f
+incdir+src
src/aluOpPkg.sv
src/hiloPkg.sv
src/iterMul.sv
src/iterDiv.sv
src/hiloReg.sv
src/aluUnit.sv
test/exe_asserts.sv
test/tb_aluUnit.sv

//--- Bender.yml
package:
  name: exe_alu

sources:
  - include_dirs:
      - src
    files:
      - src/aluOpPkg.sv
      - src/hiloPkg.sv
      - src/iterMul.sv
      - src/iterDiv.sv
      - src/hiloReg.sv
      - src/aluUnit.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/exe_asserts.sv
      - test/tb_aluUnit.sv

//--- test/tb_aluUnit.sv
`include "exe_defs.svh"

module tb_aluUnit;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int Xlen      = `EXE_XLEN;
    localparam int WaitLimit = `EXE_DIV_STEPS + 8;

    logic                    clk;
    logic                    arstN;
    logic                    stallIn;
    logic                    flush;
    logic                    flushExc;
    logic [Xlen-1:0]         srcA;
    logic [Xlen-1:0]         srcB;
    aluOpPkg::aluOp_e        aluOp;
    logic [`EXE_SHAMT_W-1:0] shamt;
    logic                    stallOut;
    hiloPkg::pair_t          result;
    logic                    overflow;

    // shared between stimulus and the compare process
    logic             checkReq;
    logic             skipLatency;
    logic             aborted;
    string            curName;
    aluOpPkg::aluOp_e curOp;
    hiloPkg::pair_t   expRes;
    logic             expOvf;
    int               expStall;
    hiloPkg::pair_t   modelPair;
    int               checks;
    int               mismatches;
    int               timeouts;
    logic [31:0]      rngState;

    aluUnit dut (
        .clk_i            (clk),
        .arstN_i          (arstN),
        .stall_i          (stallIn),
        .flush_i          (flush),
        .flushException_i (flushExc),
        .srcA_i           (srcA),
        .srcB_i           (srcB),
        .aluOp_i          (aluOp),
        .shamt_i          (shamt),
        .stall_o          (stallOut),
        .result_o         (result),
        .overflow_o       (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic aluOpPkg::opClass_e classify(input aluOpPkg::aluOp_e op);
        case (op)
            aluOpPkg::opMult, aluOpPkg::opMultu, aluOpPkg::opMul, aluOpPkg::opMadd,
            aluOpPkg::opMaddu, aluOpPkg::opMsub, aluOpPkg::opMsubu: return aluOpPkg::multiply;
            aluOpPkg::opDiv, aluOpPkg::opDivu: return aluOpPkg::divide;
            aluOpPkg::opMthi, aluOpPkg::opMtlo,
            aluOpPkg::opMfhi, aluOpPkg::opMflo: return aluOpPkg::hiloMove;
            default: return aluOpPkg::simple;
        endcase
    endfunction

    // expected result, overflow and HI/LO pair after one operation
    function automatic void refModel(
        input  aluOpPkg::aluOp_e        op,
        input  logic [Xlen-1:0]         a,
        input  logic [Xlen-1:0]         b,
        input  logic [`EXE_SHAMT_W-1:0] sh,
        input  hiloPkg::pair_t          pairIn,
        output hiloPkg::pair_t          res,
        output logic                    ovf,
        output hiloPkg::pair_t          pairOut
    );
        logic [Xlen-1:0]    w;
        logic signed [63:0] wide;
        hiloPkg::pair_t     prod;
        logic [Xlen-1:0]    quo;
        logic [Xlen-1:0]    rem;
        res     = '0;
        ovf     = 1'b0;
        pairOut = pairIn;
        w       = '0;
        case (classify(op))
            aluOpPkg::simple: begin
                case (op)
                    aluOpPkg::opNop: w = a;
                    aluOpPkg::opAnd: w = a & b;
                    aluOpPkg::opOr:  w = a | b;
                    aluOpPkg::opNor: w = ~(a | b);
                    aluOpPkg::opXor: w = a ^ b;
                    aluOpPkg::opAdd, aluOpPkg::opAddu: begin
                        wide = longint'($signed(a)) + longint'($signed(b));
                        w    = wide[Xlen-1:0];
                        // the sum fits when the upper bits all copy bit 31
                        ovf  = (op == aluOpPkg::opAdd) && (wide[63:31] != {33{wide[31]}});
                    end
                    aluOpPkg::opSub, aluOpPkg::opSubu: begin
                        wide = longint'($signed(a)) - longint'($signed(b));
                        w    = wide[Xlen-1:0];
                        ovf  = (op == aluOpPkg::opSub) && (wide[63:31] != {33{wide[31]}});
                    end
                    aluOpPkg::opSlt:  w = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    aluOpPkg::opSltu: w = (a < b) ? 32'd1 : 32'd0;
                    aluOpPkg::opSllv: w = b << a[`EXE_SHAMT_W-1:0];
                    aluOpPkg::opSrlv: w = b >> a[`EXE_SHAMT_W-1:0];
                    aluOpPkg::opSrav: w = $signed(b) >>> a[`EXE_SHAMT_W-1:0];
                    aluOpPkg::opSll:  w = b << sh;
                    aluOpPkg::opSrl:  w = b >> sh;
                    aluOpPkg::opSra:  w = $signed(b) >>> sh;
                    aluOpPkg::opLui:  w = {b[15:0], 16'h0000};
                    aluOpPkg::opSeb:  w = Xlen'($signed(b[7:0]));
                    aluOpPkg::opSeh:  w = Xlen'($signed(b[15:0]));
                    aluOpPkg::opWsbh: w = {b[23:16], b[31:24], b[7:0], b[15:8]};
                    default:          w = '0;
                endcase
                res = {{Xlen{1'b0}}, w};
            end
            aluOpPkg::multiply: begin
                if (op inside {aluOpPkg::opMult, aluOpPkg::opMul,
                               aluOpPkg::opMadd, aluOpPkg::opMsub}) begin
                    prod = longint'($signed(a)) * longint'($signed(b));
                end else begin
                    prod = {{Xlen{1'b0}}, a} * {{Xlen{1'b0}}, b};
                end
                case (op)
                    aluOpPkg::opMul:                     res = {{Xlen{1'b0}}, prod[Xlen-1:0]};
                    aluOpPkg::opMadd, aluOpPkg::opMaddu: res = pairIn + prod;
                    aluOpPkg::opMsub, aluOpPkg::opMsubu: res = pairIn - prod;
                    default:                             res = prod;
                endcase
                if (op != aluOpPkg::opMul) begin
                    pairOut = res;
                end
            end
            aluOpPkg::divide: begin
                if (op == aluOpPkg::opDiv) begin
                    quo = $signed(a) / $signed(b);
                    rem = $signed(a) % $signed(b);
                end else begin
                    quo = a / b;
                    rem = a % b;
                end
                res     = {rem, quo};
                pairOut = res;
            end
            default: begin
                case (op)
                    aluOpPkg::opMthi: begin
                        res     = {a, {Xlen{1'b0}}};
                        pairOut = {a, pairIn[Xlen-1:0]};
                    end
                    aluOpPkg::opMtlo: begin
                        res     = {{Xlen{1'b0}}, a};
                        pairOut = {pairIn[2*Xlen-1:Xlen], a};
                    end
                    aluOpPkg::opMfhi: res = {{Xlen{1'b0}}, pairIn[2*Xlen-1:Xlen]};
                    default:          res = {{Xlen{1'b0}}, pairIn[Xlen-1:0]};
                endcase
            end
        endcase
    endfunction

    task automatic compareOutputs(input int stallCycles);
        checks++;
        if (result !== expRes) begin
            $display("[FAIL] %s %s result expected %h actual %h",
                     curName, curOp.name(), expRes, result);
            mismatches++;
        end
        if (overflow !== expOvf) begin
            $display("[FAIL] %s %s overflow expected %0b actual %0b",
                     curName, curOp.name(), expOvf, overflow);
            mismatches++;
        end
        if (!skipLatency && stallCycles != expStall) begin
            $display("[FAIL] %s %s stall cycles expected %0d actual %0d",
                     curName, curOp.name(), expStall, stallCycles);
            mismatches++;
        end
    endtask

    // sample at the falling edge once stall_o has dropped
    initial begin : compareResults
        int stallCycles;
        forever begin
            @(negedge clk);
            if (checkReq) begin
                stallCycles = 0;
                while (stallOut && stallCycles < WaitLimit) begin
                    @(negedge clk);
                    stallCycles++;
                end
                if (stallOut) begin
                    $display("%s %s never finished, stall_o stayed high for %0d cycles",
                             curName, curOp.name(), stallCycles);
                    timeouts++;
                    aborted = 1'b1;
                end else begin
                    compareOutputs(stallCycles);
                end
                checkReq = 1'b0;
            end
        end
    end

    // runs from one drive point to the next
    task automatic runOp(input string name, input aluOpPkg::aluOp_e op,
                         input logic [Xlen-1:0] a, input logic [Xlen-1:0] b,
                         input logic [`EXE_SHAMT_W-1:0] sh);
        hiloPkg::pair_t nextPair;
        int             cycles;
        if (aborted) begin
            return;
        end
        refModel(op, a, b, sh, modelPair, expRes, expOvf, nextPair);
        case (classify(op))
            aluOpPkg::multiply: expStall = `EXE_MUL_STEPS + 1;
            aluOpPkg::divide:   expStall = `EXE_DIV_STEPS + 1;
            default:            expStall = 0;
        endcase
        curName  = name;
        curOp    = op;
        aluOp    = op;
        srcA     = a;
        srcB     = b;
        shamt    = sh;
        checkReq = 1'b1;
        cycles   = 0;
        while (checkReq && cycles < WaitLimit + 4) begin
            @(posedge clk);
            cycles++;
        end
        if (checkReq) begin
            $display("the check of %s %s was never completed", name, op.name());
            timeouts++;
            aborted = 1'b1;
        end
        #10;
        // HI/LO took the write at the edge just passed
        if (!stallIn && !flushExc) begin
            modelPair = nextPair;
        end
    endtask

    task automatic runThenReadHilo(input string name, input aluOpPkg::aluOp_e op,
                                   input logic [Xlen-1:0] a, input logic [Xlen-1:0] b);
        runOp(name, op, a, b, '0);
        runOp({name, " hi"}, aluOpPkg::opMfhi, '0, '0, '0);
        runOp({name, " lo"}, aluOpPkg::opMflo, '0, '0, '0);
    endtask

    initial begin : stimulus
        logic [31:0]      rnd;
        logic [Xlen-1:0]  a;
        logic [Xlen-1:0]  b;
        aluOpPkg::aluOp_e simpleOps [21];
        aluOpPkg::aluOp_e boundOps [4];
        aluOpPkg::aluOp_e accOps [4];
        arstN       = 1'b0;
        stallIn     = 1'b0;
        flush       = 1'b0;
        flushExc    = 1'b0;
        srcA        = '0;
        srcB        = '0;
        aluOp       = aluOpPkg::opNop;
        shamt       = '0;
        checkReq    = 1'b0;
        skipLatency = 1'b0;
        aborted     = 1'b0;
        modelPair   = '0;
        checks      = 0;
        mismatches  = 0;
        timeouts    = 0;
        rngState    = 32'h50e29617;
        simpleOps = '{aluOpPkg::opNop, aluOpPkg::opAnd, aluOpPkg::opOr, aluOpPkg::opNor,
                      aluOpPkg::opXor, aluOpPkg::opAdd, aluOpPkg::opAddu, aluOpPkg::opSub,
                      aluOpPkg::opSubu, aluOpPkg::opSlt, aluOpPkg::opSltu, aluOpPkg::opSllv,
                      aluOpPkg::opSrlv, aluOpPkg::opSrav, aluOpPkg::opSll, aluOpPkg::opSrl,
                      aluOpPkg::opSra, aluOpPkg::opLui, aluOpPkg::opSeb, aluOpPkg::opSeh,
                      aluOpPkg::opWsbh};
        boundOps = '{aluOpPkg::opAdd, aluOpPkg::opSub, aluOpPkg::opAddu, aluOpPkg::opSubu};
        accOps   = '{aluOpPkg::opMadd, aluOpPkg::opMaddu, aluOpPkg::opMsub, aluOpPkg::opMsubu};

        repeat (10) @(posedge clk);
        #10;
        arstN = 1'b1;
        @(posedge clk);
        #10;

        for (int i = 0; i < 48; i++) begin
            rnd = nextRandom();
            runOp("random simple", simpleOps[int'(rnd % 32'd21)], nextRandom(),
                  nextRandom(), rnd[12:8]);
        end

        // operands at the edges of the signed range
        runOp("add overflow", aluOpPkg::opAdd, 32'h7fff_ffff, 32'h0000_0001, '0);
        runOp("add overflow", aluOpPkg::opAdd, 32'h8000_0000, 32'hffff_ffff, '0);
        runOp("add in range", aluOpPkg::opAdd, 32'h7fff_ffff, 32'hffff_ffff, '0);
        runOp("sub overflow", aluOpPkg::opSub, 32'h8000_0000, 32'h0000_0001, '0);
        runOp("sub overflow", aluOpPkg::opSub, 32'h7fff_ffff, 32'hffff_ffff, '0);
        runOp("addu no trap", aluOpPkg::opAddu, 32'h7fff_ffff, 32'h0000_0001, '0);
        runOp("subu no trap", aluOpPkg::opSubu, 32'h8000_0000, 32'h0000_0001, '0);
        for (int i = 0; i < 16; i++) begin
            rnd = nextRandom();
            a = {rnd[0], {23{~rnd[0]}}, rnd[15:8]};
            b = {rnd[1], {23{~rnd[1]}}, rnd[23:16]};
            runOp("range edge", boundOps[i % 4], a, b, '0);
        end

        for (int i = 0; i < 4; i++) begin
            a = nextRandom();
            b = nextRandom();
            runThenReadHilo("mult", aluOpPkg::opMult, a, b);
            runThenReadHilo("multu", aluOpPkg::opMultu, a, b);
            runThenReadHilo("mul", aluOpPkg::opMul, b, a);
        end

        for (int i = 0; i < 4; i++) begin
            a = nextRandom();
            rnd = nextRandom();
            // spread the divisor over many magnitudes
            b = nextRandom() >> rnd[4:0];
            if (rnd[5]) begin
                b = -b;
            end
            if (b == '0) begin
                b = 32'd3;
            end
            runThenReadHilo("div", aluOpPkg::opDiv, a, b);
            runThenReadHilo("divu", aluOpPkg::opDivu, a, b);
        end
        runThenReadHilo("div negative", aluOpPkg::opDiv, 32'hffff_fff9, 32'd2);
        runThenReadHilo("div negative", aluOpPkg::opDiv, 32'd7, 32'hffff_fffe);

        for (int i = 0; i < 3; i++) begin
            runThenReadHilo("mthi", aluOpPkg::opMthi, nextRandom(), '0);
            runThenReadHilo("mtlo", aluOpPkg::opMtlo, nextRandom(), '0);
            for (int k = 0; k < 4; k++) begin
                runThenReadHilo("accumulate", accOps[k], nextRandom(), nextRandom());
            end
        end

        // finished MULT held by back-pressure
        a = nextRandom();
        b = nextRandom();
        stallIn = 1'b1;
        runOp("held mult", aluOpPkg::opMult, a, b, '0);
        skipLatency = 1'b1;
        runOp("held mult", aluOpPkg::opMult, a, b, '0);
        runOp("held mult", aluOpPkg::opMult, a, b, '0);
        runOp("held mfhi", aluOpPkg::opMfhi, '0, '0, '0);
        stallIn = 1'b0;
        runOp("released mult", aluOpPkg::opMult, a, b, '0);
        skipLatency = 1'b0;
        runThenReadHilo("after release", aluOpPkg::opNop, '0, '0);

        // HI write squashed by an exception
        flushExc = 1'b1;
        runOp("flushed mthi", aluOpPkg::opMthi, nextRandom(), '0, '0);
        flushExc = 1'b0;
        runOp("flushed mthi hi", aluOpPkg::opMfhi, '0, '0, '0);

        $display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
                 checks, mismatches, timeouts, dut.uAsserts.failCount);
        if (mismatches == 0 && timeouts == 0 && !aborted && checks > 0
                && dut.uAsserts.failCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- test/exe_asserts.sv
`include "exe_defs.svh"

module exeAsserts (
    input logic             clk_i,
    input logic             arstN_i,
    input logic             stallOut_i,
    input logic             ovfOut_i,
    input aluOpPkg::aluOp_e aluOp_i,
    input logic             mulReady_i,
    input logic             divReady_i,
    input logic [1:0]       mulState_i,
    input logic [1:0]       divState_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // IDLE is the first state of both unit FSMs
    localparam logic [1:0] Idle = 2'd0;

    int failCount = 0;

    // the divider is the longest operation
    stallBounded: assert property (@(posedge clk_i) disable iff (!arstN_i)
        $rose(stallOut_i) |-> ##[1:`EXE_DIV_STEPS + 2] !stallOut_i)
        else begin
            failCount++;
            $error("stall_o stayed high longer than a divide takes");
        end

    mulNotFromIdle: assert property (@(posedge clk_i) disable iff (!arstN_i)
        (mulState_i == Idle) |=> !$rose(mulReady_i))
        else begin
            failCount++;
            $error("multiplier ready rose right after IDLE");
        end

    divNotFromIdle: assert property (@(posedge clk_i) disable iff (!arstN_i)
        (divState_i == Idle) |=> !$rose(divReady_i))
        else begin
            failCount++;
            $error("divider ready rose right after IDLE");
        end

    // only the trapping add and subtract flag overflow
    ovfOnlyAddSub: assert property (@(posedge clk_i) disable iff (!arstN_i)
        ovfOut_i |-> (aluOp_i inside {aluOpPkg::opAdd, aluOpPkg::opSub}))
        else begin
            failCount++;
            $error("overflow_o high for an operation other than ADD or SUB");
        end

endmodule

bind aluUnit exeAsserts uAsserts (
    .clk_i      (clk_i),
    .arstN_i    (arstN_i),
    .stallOut_i (stall_o),
    .ovfOut_i   (overflow_o),
    .aluOp_i    (aluOp_i),
    .mulReady_i (mulReady),
    .divReady_i (divReady),
    .mulState_i (uMul.state),
    .divState_i (uDiv.state)
);

//--- src/aluUnit.sv
`include "exe_defs.svh"

module aluUnit (
    input  logic                    clk_i,
    input  logic                    arstN_i,
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  logic                    flushException_i,
    input  logic [`EXE_XLEN-1:0]    srcA_i,
    input  logic [`EXE_XLEN-1:0]    srcB_i,
    input  aluOpPkg::aluOp_e        aluOp_i,
    input  logic [`EXE_SHAMT_W-1:0] shamt_i,
    output logic                    stall_o,
    output hiloPkg::pair_t          result_o,
    output logic                    overflow_o
);
    localparam int Msb     = `EXE_XLEN - 1;
    localparam int PairMsb = 2 * `EXE_XLEN - 1;

    aluOpPkg::opClass_e opClass;
    logic [Msb:0]       simpleRes;
    logic [Msb:0]       sum;
    logic [Msb:0]       diff;
    logic               addOvf;
    logic               subOvf;
    logic               mulStart;
    logic               mulSigned;
    logic               mulReady;
    logic               divStart;
    logic               divSigned;
    logic               divReady;
    hiloPkg::pair_t     mulRes;
    hiloPkg::pair_t     divRes;
    hiloPkg::pair_t     mulPair;
    hiloPkg::pair_t     hilo;
    hiloPkg::hiloSel_e  hiloSel;
    logic               hiloWrite;
    logic               hiloWe;

    assign opClass = aluOpPkg::opClassOf(aluOp_i);

    assign sum  = srcA_i + srcB_i;
    assign diff = srcA_i - srcB_i;
    // signed overflow from operand and result signs
    assign addOvf = (srcA_i[Msb] == srcB_i[Msb]) && (sum[Msb] != srcA_i[Msb]);
    assign subOvf = (srcA_i[Msb] != srcB_i[Msb]) && (diff[Msb] != srcA_i[Msb]);

    always_comb begin
        case (aluOp_i)
            aluOpPkg::opNop:  simpleRes = srcA_i;
            aluOpPkg::opAnd:  simpleRes = srcA_i & srcB_i;
            aluOpPkg::opOr:   simpleRes = srcA_i | srcB_i;
            aluOpPkg::opNor:  simpleRes = ~(srcA_i | srcB_i);
            aluOpPkg::opXor:  simpleRes = srcA_i ^ srcB_i;
            aluOpPkg::opAdd,
            aluOpPkg::opAddu: simpleRes = sum;
            aluOpPkg::opSub,
            aluOpPkg::opSubu: simpleRes = diff;
            aluOpPkg::opSlt:  simpleRes = {{Msb{1'b0}}, $signed(srcA_i) < $signed(srcB_i)};
            aluOpPkg::opSltu: simpleRes = {{Msb{1'b0}}, srcA_i < srcB_i};
            // variable shifts take the amount from srcA
            aluOpPkg::opSllv: simpleRes = srcB_i << srcA_i[`EXE_SHAMT_W-1:0];
            aluOpPkg::opSrlv: simpleRes = srcB_i >> srcA_i[`EXE_SHAMT_W-1:0];
            aluOpPkg::opSrav: simpleRes = $signed(srcB_i) >>> srcA_i[`EXE_SHAMT_W-1:0];
            aluOpPkg::opSll:  simpleRes = srcB_i << shamt_i;
            aluOpPkg::opSrl:  simpleRes = srcB_i >> shamt_i;
            aluOpPkg::opSra:  simpleRes = $signed(srcB_i) >>> shamt_i;
            aluOpPkg::opLui:  simpleRes = {srcB_i[15:0], 16'h0000};
            aluOpPkg::opSeb:  simpleRes = {{24{srcB_i[7]}}, srcB_i[7:0]};
            aluOpPkg::opSeh:  simpleRes = {{16{srcB_i[15]}}, srcB_i[15:0]};
            // swap bytes within each halfword
            aluOpPkg::opWsbh: simpleRes = {srcB_i[23:16], srcB_i[31:24], srcB_i[7:0], srcB_i[15:8]};
            default:          simpleRes = '0;
        endcase
    end

    // start stays high as a level for the whole operation
    assign mulStart  = (opClass == aluOpPkg::multiply);
    assign divStart  = (opClass == aluOpPkg::divide);
    assign mulSigned = aluOp_i inside {aluOpPkg::opMult, aluOpPkg::opMul,
                                       aluOpPkg::opMadd, aluOpPkg::opMsub};
    assign divSigned = (aluOp_i == aluOpPkg::opDiv);

    // accumulate against the stored pair
    always_comb begin
        case (aluOp_i)
            aluOpPkg::opMadd, aluOpPkg::opMaddu: mulPair = hilo + mulRes;
            aluOpPkg::opMsub, aluOpPkg::opMsubu: mulPair = hilo - mulRes;
            aluOpPkg::opMul: mulPair = {{`EXE_XLEN{1'b0}}, mulRes[Msb:0]};
            default:         mulPair = mulRes;
        endcase
    end

    always_comb begin
        result_o   = '0;
        overflow_o = 1'b0;
        stall_o    = 1'b0;
        hiloWrite  = 1'b0;
        hiloSel    = hiloPkg::both;
        case (opClass)
            aluOpPkg::simple: begin
                result_o   = {{`EXE_XLEN{1'b0}}, simpleRes};
                overflow_o = ((aluOp_i == aluOpPkg::opAdd) && addOvf)
                          || ((aluOp_i == aluOpPkg::opSub) && subOvf);
            end
            aluOpPkg::multiply: begin
                stall_o = !mulReady;
                if (mulReady) begin
                    result_o  = mulPair;
                    // MUL only returns the low word
                    hiloWrite = (aluOp_i != aluOpPkg::opMul);
                end
            end
            aluOpPkg::divide: begin
                stall_o = !divReady;
                if (divReady) begin
                    result_o  = divRes;
                    hiloWrite = 1'b1;
                end
            end
            aluOpPkg::hiloMove: begin
                case (aluOp_i)
                    aluOpPkg::opMthi: begin
                        result_o  = {srcA_i, {`EXE_XLEN{1'b0}}};
                        hiloSel   = hiloPkg::hiOnly;
                        hiloWrite = 1'b1;
                    end
                    aluOpPkg::opMtlo: begin
                        result_o  = {{`EXE_XLEN{1'b0}}, srcA_i};
                        hiloSel   = hiloPkg::loOnly;
                        hiloWrite = 1'b1;
                    end
                    aluOpPkg::opMfhi: result_o = {{`EXE_XLEN{1'b0}}, hilo[PairMsb:`EXE_XLEN]};
                    default:          result_o = {{`EXE_XLEN{1'b0}}, hilo[Msb:0]};
                endcase
            end
            default: result_o = '0;
        endcase
    end

    // no write while the pipeline holds or an exception flushes
    assign hiloWe = hiloWrite && !stall_i && !flushException_i;

    iterMul uMul (
        .clk_i    (clk_i),
        .arstN_i  (arstN_i),
        .flush_i  (flush_i),
        .start_i  (mulStart),
        .signed_i (mulSigned),
        .stall_i  (stall_i),
        .opA_i    (srcA_i),
        .opB_i    (srcB_i),
        .ready_o  (mulReady),
        .result_o (mulRes)
    );

    iterDiv uDiv (
        .clk_i    (clk_i),
        .arstN_i  (arstN_i),
        .flush_i  (flush_i),
        .start_i  (divStart),
        .signed_i (divSigned),
        .stall_i  (stall_i),
        .opA_i    (srcA_i),
        .opB_i    (srcB_i),
        .ready_o  (divReady),
        .result_o (divRes)
    );

    hiloReg uHilo (
        .clk_i   (clk_i),
        .arstN_i (arstN_i),
        .we_i    (hiloWe),
        .sel_i   (hiloSel),
        .wdata_i (result_o),
        .hilo_o  (hilo)
    );

endmodule

//--- src/hiloReg.sv
`include "exe_defs.svh"

module hiloReg (
    input  logic                clk_i,
    input  logic                arstN_i,
    input  logic                we_i,
    input  hiloPkg::hiloSel_e   sel_i,
    input  hiloPkg::pair_t      wdata_i,
    output hiloPkg::pair_t      hilo_o
);
    localparam int Msb     = `EXE_XLEN - 1;
    localparam int PairMsb = 2 * `EXE_XLEN - 1;

    logic [Msb:0] hi;
    logic [Msb:0] lo;

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            hi <= '0;
            lo <= '0;
        end else if (we_i) begin
            case (sel_i)
                hiloPkg::both: begin
                    hi <= wdata_i[PairMsb:`EXE_XLEN];
                    lo <= wdata_i[Msb:0];
                end
                // MTHI keeps LO
                hiloPkg::hiOnly: hi <= wdata_i[PairMsb:`EXE_XLEN];
                // MTLO keeps HI
                hiloPkg::loOnly: lo <= wdata_i[Msb:0];
                default: begin
                    hi <= hi;
                    lo <= lo;
                end
            endcase
        end
    end

    // read side is combinational so MFHI/MFLO see the pair at once
    assign hilo_o = {hi, lo};

endmodule

//--- src/iterDiv.sv
`include "exe_defs.svh"

module iterDiv (
    input  logic                 clk_i,
    input  logic                 arstN_i,
    input  logic                 flush_i,
    input  logic                 start_i,
    input  logic                 signed_i,
    input  logic                 stall_i,
    input  logic [`EXE_XLEN-1:0] opA_i,
    input  logic [`EXE_XLEN-1:0] opB_i,
    output logic                 ready_o,
    output hiloPkg::pair_t       result_o
);
    localparam int Msb     = `EXE_XLEN - 1;
    localparam int PairMsb = 2 * `EXE_XLEN - 1;
    localparam int CntW    = $clog2(`EXE_DIV_STEPS);

    typedef enum logic [1:0] {IDLE, BUSY, DONE} state_e;

    state_e          state;
    state_e          stateNext;
    logic [CntW-1:0] stepCnt;
    logic            lastStep;
    logic [Msb:0]    magA;
    logic [Msb:0]    magB;
    logic [Msb:0]    divisor;
    hiloPkg::pair_t  rem;
    logic [Msb+2:0]  trial;
    logic            quoNeg;
    logic            remNeg;
    logic [Msb:0]    remOut;
    logic [Msb:0]    quoOut;

    assign magA = (signed_i && opA_i[Msb]) ? -opA_i : opA_i;
    assign magB = (signed_i && opB_i[Msb]) ? -opB_i : opB_i;
    assign lastStep = (stepCnt == CntW'(`EXE_DIV_STEPS - 1));

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: if (start_i) stateNext = BUSY;
            BUSY: if (lastStep) stateNext = DONE;
            DONE: if (!stall_i) stateNext = IDLE;
            default: stateNext = IDLE;
        endcase
        if (flush_i) begin
            stateNext = IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            state   <= IDLE;
            stepCnt <= '0;
        end else begin
            state <= stateNext;
            if (state == BUSY) begin
                stepCnt <= stepCnt + 1'b1;
            end else begin
                stepCnt <= '0;
            end
        end
    end

    // shifted partial remainder minus divisor
    // 33 bits of remainder since the shift can carry out of the upper word
    assign trial = {1'b0, rem[PairMsb:Msb]} - {2'b00, divisor};

    // restoring division with quotient bits shifting into the low word
    always_ff @(posedge clk_i) begin
        if (state == IDLE && start_i) begin
            rem     <= {{`EXE_XLEN{1'b0}}, magA};
            divisor <= magB;
            quoNeg  <= signed_i && (opA_i[Msb] ^ opB_i[Msb]);
            remNeg  <= signed_i && opA_i[Msb];
        end else if (state == BUSY) begin
            if (trial[Msb+2]) begin
                rem <= {rem[PairMsb-1:0], 1'b0};
            end else begin
                rem <= {trial[Msb:0], rem[Msb-1:0], 1'b1};
            end
        end
    end

    // remainder follows the dividend sign
    assign remOut = remNeg ? -rem[PairMsb:`EXE_XLEN] : rem[PairMsb:`EXE_XLEN];
    assign quoOut = quoNeg ? -rem[Msb:0] : rem[Msb:0];

    assign ready_o  = (state == DONE);
    assign result_o = {remOut, quoOut};

endmodule

//--- src/iterMul.sv
`include "exe_defs.svh"

module iterMul (
    input  logic                 clk_i,
    input  logic                 arstN_i,
    input  logic                 flush_i,
    input  logic                 start_i,
    input  logic                 signed_i,
    input  logic                 stall_i,
    input  logic [`EXE_XLEN-1:0] opA_i,
    input  logic [`EXE_XLEN-1:0] opB_i,
    output logic                 ready_o,
    output hiloPkg::pair_t       result_o
);
    localparam int Msb  = `EXE_XLEN - 1;
    localparam int CntW = $clog2(`EXE_MUL_STEPS);

    typedef enum logic [1:0] {IDLE, BUSY, DONE} state_e;

    state_e          state;
    state_e          stateNext;
    logic [CntW-1:0] stepCnt;
    logic            lastStep;
    logic [Msb:0]    magA;
    logic [Msb:0]    magB;
    logic [Msb:0]    mplier;
    hiloPkg::pair_t  mcand;
    hiloPkg::pair_t  prod;
    logic            negate;

    // iterate on magnitudes and restore the sign at the end
    assign magA = (signed_i && opA_i[Msb]) ? -opA_i : opA_i;
    assign magB = (signed_i && opB_i[Msb]) ? -opB_i : opB_i;
    assign lastStep = (stepCnt == CntW'(`EXE_MUL_STEPS - 1));

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: if (start_i) stateNext = BUSY;
            BUSY: if (lastStep) stateNext = DONE;
            // hold the product while the pipeline is stalled
            DONE: if (!stall_i) stateNext = IDLE;
            default: stateNext = IDLE;
        endcase
        if (flush_i) begin
            stateNext = IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            state   <= IDLE;
            stepCnt <= '0;
        end else begin
            state <= stateNext;
            if (state == BUSY) begin
                stepCnt <= stepCnt + 1'b1;
            end else begin
                stepCnt <= '0;
            end
        end
    end

    // shift-add, one multiplier bit per step
    always_ff @(posedge clk_i) begin
        if (state == IDLE && start_i) begin
            mcand  <= {{`EXE_XLEN{1'b0}}, magA};
            mplier <= magB;
            prod   <= '0;
            negate <= signed_i && (opA_i[Msb] ^ opB_i[Msb]);
        end else if (state == BUSY) begin
            if (mplier[0]) begin
                prod <= prod + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign ready_o  = (state == DONE);
    assign result_o = negate ? -prod : prod;

endmodule

//--- src/hiloPkg.sv
`include "exe_defs.svh"

package hiloPkg;

    // which half of the pair a write replaces
    typedef enum logic [1:0] {
        both   = 2'd0,
        hiOnly = 2'd1,
        loOnly = 2'd2
    } hiloSel_e;

    // HI in the upper word, LO in the lower word
    typedef logic [2*`EXE_XLEN-1:0] pair_t;

endpackage

//--- src/aluOpPkg.sv
package aluOpPkg;

    // operation codes seen by the execute stage
    typedef enum logic [7:0] {
        opNop   = 8'h00,
        // logic
        opAnd   = 8'h01,
        opOr    = 8'h02,
        opNor   = 8'h03,
        opXor   = 8'h04,
        // add and subtract
        opAdd   = 8'h08,
        opAddu  = 8'h09,
        opSub   = 8'h0a,
        opSubu  = 8'h0b,
        opSlt   = 8'h0c,
        opSltu  = 8'h0d,
        // shifts by srcA
        opSllv  = 8'h10,
        opSrlv  = 8'h11,
        opSrav  = 8'h12,
        // shifts by shamt
        opSll   = 8'h14,
        opSrl   = 8'h15,
        opSra   = 8'h16,
        opLui   = 8'h18,
        opSeb   = 8'h19,
        opSeh   = 8'h1a,
        opWsbh  = 8'h1b,
        // multiplier ops
        opMult  = 8'h20,
        opMultu = 8'h21,
        opMul   = 8'h22,
        opMadd  = 8'h24,
        opMaddu = 8'h25,
        opMsub  = 8'h26,
        opMsubu = 8'h27,
        // divider ops
        opDiv   = 8'h28,
        opDivu  = 8'h29,
        // HI/LO moves
        opMthi  = 8'h30,
        opMtlo  = 8'h31,
        opMfhi  = 8'h32,
        opMflo  = 8'h33
    } aluOp_e;

    // which path of the unit serves an operation
    typedef enum logic [1:0] {
        simple   = 2'd0,
        multiply = 2'd1,
        divide   = 2'd2,
        hiloMove = 2'd3
    } opClass_e;

    function automatic opClass_e opClassOf(aluOp_e op);
        case (op)
            opMult, opMultu, opMul, opMadd, opMaddu, opMsub, opMsubu: return multiply;
            opDiv, opDivu: return divide;
            opMthi, opMtlo, opMfhi, opMflo: return hiloMove;
            default: return simple;
        endcase
    endfunction

endpackage

//--- src/exe_defs.svh
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

// datapath word width
`define EXE_XLEN 32

// width of the immediate and variable shift amount
`define EXE_SHAMT_W 5

// iteration counts of the sequential units
// one product bit per step
`define EXE_MUL_STEPS 32
// one quotient bit per step
`define EXE_DIV_STEPS 32

`endif
